// File: design/frame_fifo.sv
// ---------------------------------------------------------------------
// Frame buffer
// A small circular buffer of frames between the counting side and the
// UART side, with a sticky flag for frames lost to a full buffer.
// ---------------------------------------------------------------------

module frame_fifo (
    input  logic              clki,
    input  logic              reset,
    input  logic              push,
    input  xc_pkg::xc_frame_t wr_frame,
    input  logic              pop,
    output xc_pkg::xc_frame_t head,
    output logic              not_empty,
    output logic              overflow
);

    xc_pkg::xc_frame_t               mem [xc_pkg::fifo_depth];  // frame storage.
    logic [xc_pkg::fifo_ptr_width-1:0] wr_ptr;                  // next entry to fill.
    logic [xc_pkg::fifo_ptr_width-1:0] rd_ptr;                  // oldest stored entry.
    logic [xc_pkg::fifo_cnt_width-1:0] count;                   // frames currently held.
    logic                              full;
    logic                              do_push;
    logic                              do_pop;

    // Steps a pointer forward and wraps it after the last entry.
    function automatic logic [xc_pkg::fifo_ptr_width-1:0] ptr_inc(
        input logic [xc_pkg::fifo_ptr_width-1:0] ptr
    );
        if (ptr == xc_pkg::fifo_ptr_width'(xc_pkg::fifo_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == xc_pkg::fifo_cnt_width'(xc_pkg::fifo_depth));
    assign not_empty = (count != '0);
    assign do_push   = push & ~full;       // a frame that finds no room is lost.
    assign do_pop    = pop & not_empty;    // an empty buffer ignores a pop.
    assign head      = mem[rd_ptr];        // the oldest frame is always on show.

    always_ff @(posedge clki) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_frame;
        end
    end

    always_ff @(posedge clki) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // both or neither leave the level alone.
            endcase
            overflow <= overflow | (push & full);    // stays up until the next reset.
        end
    end

endmodule

// File: design/pulse_correlator.sv
// ---------------------------------------------------------------------
// Pulse correlator
// Finds rising edges on both detector lines, counts them and their
// lag 0 and lag 1 coincidences over fixed windows, and strobes one
// frame out at the close of each window.
// ---------------------------------------------------------------------

module pulse_correlator (
    input  logic                         clki,
    input  logic                         reset,
    input  logic                         enable,
    input  logic [xc_pkg::num_lines-1:0] line_in,
    output xc_pkg::xc_frame_t            frame,
    output logic                         frame_valid
);

    logic [xc_pkg::num_lines-1:0] line_q;      // holds the previous sample of each line.
    logic [xc_pkg::num_lines-1:0] edge_now;    // flags an edge in the current sample.
    logic [xc_pkg::num_lines-1:0] edge_q;      // registered edges that belong to a window.
    logic                         prev_edge0;  // line 0 edge of the cycle before edge_q.
    logic                         active;      // a window is running.
    logic [xc_pkg::win_width-1:0] win_cnt;     // position inside the running window.
    logic                         start;       // this cycle opens a new window.
    logic                         in_win;      // this cycle's sample belongs to a window.
    logic                         last;        // this cycle is the final one of the window.
    xc_pkg::xc_frame_t            acc;         // running totals of the open window.

    // Adds one unless the counter already sits at its ceiling.
    function automatic logic [xc_pkg::count_width-1:0] sat_inc(
        input logic [xc_pkg::count_width-1:0] value,
        input logic                           inc
    );
        if (inc && (value != '1)) begin
            return value + 1'b1;
        end
        return value;
    endfunction

    // ---------------------------------------------------------------------
    // edge detection and window control
    // ---------------------------------------------------------------------
    assign edge_now = line_in & ~line_q;    // a high sample after a low one is an edge.
    assign start    = enable & ~active;     // a window opens once enable is seen while idle.
    assign in_win   = active | start;       // the opening cycle already counts.
    assign last     = active &&
                      (win_cnt == xc_pkg::win_width'(xc_pkg::window_cycles - 1));

    // ---------------------------------------------------------------------
    // totals including the edges still in the pipeline
    // ---------------------------------------------------------------------
    // The frame is the accumulator plus this cycle's registered edges, so in
    // the strobe cycle it already holds the edge of the window's last sample.
    always_comb begin
        frame.count0     = sat_inc(acc.count0, edge_q[0]);               // line 0 pulses.
        frame.count1     = sat_inc(acc.count1, edge_q[1]);               // line 1 pulses.
        frame.coinc_lag0 = sat_inc(acc.coinc_lag0, edge_q[0] & edge_q[1]);  // same cycle.
        frame.coinc_lag1 = sat_inc(acc.coinc_lag1, prev_edge0 & edge_q[1]); // one cycle apart.
    end

    always_ff @(posedge clki) begin
        if (reset) begin
            line_q      <= '0;
            edge_q      <= '0;
            prev_edge0  <= 1'b0;
            active      <= 1'b0;
            win_cnt     <= '0;
            frame_valid <= 1'b0;
            acc         <= '0;
        end else begin
            line_q      <= line_in;                                    // keeps the last sample.
            edge_q      <= edge_now & {xc_pkg::num_lines{in_win}};     // drops edges outside windows.
            prev_edge0  <= start ? 1'b0 : edge_q[0];                   // no lag 1 across a boundary.
            frame_valid <= last;                                       // strobes right after the close.
            acc         <= frame_valid ? '0 : frame;                   // clears as the frame leaves.
            if (start) begin
                active  <= 1'b1;                                       // the opening cycle is index 0.
                win_cnt <= xc_pkg::win_width'(1);
            end else if (last) begin
                active  <= 1'b0;                                       // enable decides what comes next.
                win_cnt <= '0;
            end else if (active) begin
                win_cnt <= win_cnt + 1'b1;
            end
        end
    end

endmodule

// File: design/uart_framer.sv
// ---------------------------------------------------------------------
// UART framer
// Takes frames from the buffer and sends each one as a sync byte and
// eight data bytes, 8N1, least significant bit first.
// ---------------------------------------------------------------------

module uart_framer (
    input  logic              clki,
    input  logic              reset,
    input  logic              not_empty,
    input  xc_pkg::xc_frame_t head,
    output logic              pop,
    output logic              tx
);

    xc_pkg::xc_frame_t             frame_q;   // the frame being sent.
    logic                          busy;      // a frame is on the line.
    logic [3:0]                    byte_idx;  // byte 0 is sync, bytes 1 to 8 are data.
    logic [3:0]                    bit_idx;   // bit 0 is start, 1 to 8 data, 9 stop.
    logic [xc_pkg::baud_width-1:0] baud;      // cycles spent in the current bit.
    logic [9:0]                    shift_q;   // stop, data and start bits of one byte.

    // Picks byte idx of the outgoing frame, each field low byte first.
    function automatic logic [7:0] frame_byte(
        input xc_pkg::xc_frame_t f,
        input logic [3:0]        idx
    );
        case (idx)
            4'd1:    return f.count0[7:0];
            4'd2:    return f.count0[15:8];
            4'd3:    return f.count1[7:0];
            4'd4:    return f.count1[15:8];
            4'd5:    return f.coinc_lag0[7:0];
            4'd6:    return f.coinc_lag0[15:8];
            4'd7:    return f.coinc_lag1[7:0];
            4'd8:    return f.coinc_lag1[15:8];
            default: return xc_pkg::sync_byte;
        endcase
    endfunction

    assign pop = ~busy & not_empty;   // pops only between frames.
    assign tx  = shift_q[0];          // the line idles high with all ones loaded.

    always_ff @(posedge clki) begin
        if (pop) begin
            frame_q <= head;          // taken in the same cycle as the pop.
        end
    end

    // ---------------------------------------------------------------------
    // bit and byte sequencing
    // ---------------------------------------------------------------------
    always_ff @(posedge clki) begin
        if (reset) begin
            busy     <= 1'b0;
            byte_idx <= '0;
            bit_idx  <= '0;
            baud     <= '0;
            shift_q  <= '1;
        end else if (pop) begin
            busy     <= 1'b1;
            byte_idx <= '0;
            bit_idx  <= '0;
            baud     <= '0;
            shift_q  <= {1'b1, xc_pkg::sync_byte, 1'b0};    // the sync byte goes first.
        end else if (busy) begin
            if (baud == xc_pkg::baud_width'(xc_pkg::clks_per_bit - 1)) begin
                baud <= '0;
                if (bit_idx == 4'd9) begin
                    bit_idx <= '0;                           // the stop bit is done.
                    if (byte_idx == 4'd8) begin
                        busy <= 1'b0;                        // idle for at least one cycle.
                    end else begin
                        byte_idx <= byte_idx + 1'b1;
                        shift_q  <= {1'b1, frame_byte(frame_q, byte_idx + 4'd1), 1'b0};
                    end
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                    shift_q <= {1'b1, shift_q[9:1]};         // ones fill in behind the stop bit.
                end
            end else begin
                baud <= baud + 1'b1;
            end
        end
    end

endmodule

// File: design/xc_core.sv
// ---------------------------------------------------------------------
// Correlator core
// Counting side, frame buffer and UART framer joined into one block
// with the detector lines in and a serial line out.
// ---------------------------------------------------------------------

module xc_core (
    input  logic       clki,
    input  logic       reset,
    input  logic       enable,
    input  logic [1:0] line_in,
    output logic       tx,
    output logic       overflow
);

    xc_pkg::xc_frame_t frame;        // a finished window from the counting side.
    logic              frame_valid;  // one cycle strobe for the frame above.
    xc_pkg::xc_frame_t head;         // oldest buffered frame.
    logic              not_empty;    // the buffer holds at least one frame.
    logic              pop;          // the framer takes the head frame.

    pulse_correlator correlator_i (
        .clki        (clki),
        .reset       (reset),
        .enable      (enable),
        .line_in     (line_in),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    frame_fifo fifo_i (
        .clki      (clki),
        .reset     (reset),
        .push      (frame_valid),
        .wr_frame  (frame),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .overflow  (overflow)
    );

    uart_framer framer_i (
        .clki      (clki),
        .reset     (reset),
        .not_empty (not_empty),
        .head      (head),
        .pop       (pop),
        .tx        (tx)
    );

endmodule

// File: design/xc_pkg.sv
// ---------------------------------------------------------------------
// Correlator shared definitions
// Holds the frame layout, counter and window sizes, the UART bit time,
// the frame sync byte and the frame buffer depth.
// ---------------------------------------------------------------------

package xc_pkg;

    // ---------------------------------------------------------------------
    // counting side
    // ---------------------------------------------------------------------
    localparam int num_lines     = 2;                      // two detector lines are counted.
    localparam int count_width   = 16;                     // each counter saturates at all ones.
    localparam int window_cycles = 1024;                   // one integration window in cycles.
    localparam int win_width     = $clog2(window_cycles);  // wide enough to index one window.

    // ---------------------------------------------------------------------
    // serial side
    // ---------------------------------------------------------------------
    localparam int         clks_per_bit = 8;                     // one UART bit in clock cycles.
    localparam int         baud_width   = $clog2(clks_per_bit);  // width of the bit timer.
    localparam logic [7:0] sync_byte    = 8'hA5;                 // every frame opens with this.

    // ---------------------------------------------------------------------
    // frame buffer
    // ---------------------------------------------------------------------
    localparam int fifo_depth     = 4;                        // frames held between the two sides.
    localparam int fifo_ptr_width = $clog2(fifo_depth);       // addresses one buffer entry.
    localparam int fifo_cnt_width = $clog2(fifo_depth + 1);   // counts zero up to a full buffer.

    // One finished window. The four fields go out on the line in the
    // order they are declared here, each one low byte first.
    typedef struct packed {
        logic [count_width-1:0] count0;      // rising edges seen on line 0.
        logic [count_width-1:0] count1;      // rising edges seen on line 1.
        logic [count_width-1:0] coinc_lag0;  // cycles where both lines had an edge.
        logic [count_width-1:0] coinc_lag1;  // line 1 edges one cycle after a line 0 edge.
    } xc_frame_t;

endpackage

// File: dv/clock_gen.sv
// ---------------------------------------------------------------------
// Testbench clock and reset
// Free running clock and a synchronous reset held for a set number of
// cycles at the start of the run.
// ---------------------------------------------------------------------

module clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 8
) (
    output logic clki,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clki = 1'b0;
        forever #(period_ns / 2) clki = ~clki;        // even duty cycle.
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clki);
        reset <= 1'b0;                                // released on a rising edge like the DUT inputs.
    end

endmodule

// File: dv/xc_properties.sv
// ---------------------------------------------------------------------
// Buffer and UART line properties
// Bound into the correlator core, where the buffer handshake, the
// overflow flag and the serial line all meet.
// ---------------------------------------------------------------------

module xc_properties (
    input logic clki,
    input logic reset,
    input logic pop,
    input logic not_empty,
    input logic overflow,
    input logic tx
);
    timeunit 1ns;
    timeprecision 1ps;

    int errors = 0;    // failed assertions so far, watched from the testbench.

    // a pop may only take a frame that is really there.
    pop_needs_frame: assert property (@(posedge clki) disable iff (reset) pop |-> not_empty)
        else begin
            errors++;
            $error("pop raised while the buffer is empty");
        end

    // the line must idle high as soon as reset has been seen.
    tx_idles_after_reset: assert property (@(posedge clki) reset |=> tx)
        else begin
            errors++;
            $error("tx is not high in the cycle after reset");
        end

    // lost frames stay flagged until the next reset.
    overflow_sticks: assert property (@(posedge clki) (!reset && overflow) |=> (overflow || reset))
        else begin
            errors++;
            $error("overflow fell without a reset");
        end

endmodule

bind xc_core xc_properties core_checks_i (
    .clki      (clki),
    .reset     (reset),
    .pop       (pop),
    .not_empty (not_empty),
    .overflow  (overflow),
    .tx        (tx)
);

// File: dv/xc_stimulus.txt
# period0 period1 offset1 jitter count0 count1 coinc_lag0 coinc_lag1, all hex, one window per line.
# period 0 keeps a line low, period 1 holds it high, counts are before any jitter.
10 10 0 0 40 40 40 0
10 10 1 0 40 40 0 40
a 19 0 0 67 29 15 0
7 d 5 0 93 4f b b
0 0 0 0 0 0 0 0
1 0 0 0 1 0 0 0
1 1 0 0 0 1 0 0
14 14 0 1 33 33 33 0
c 9 3 1 56 72 1d 0
8 8 1 1 80 80 0 80
3 6 1 0 156 ab 0 ab
2 4 0 0 1ff 100 ff 0

// File: dv/xc_tb.sv
// ---------------------------------------------------------------------
// Correlator testbench
// Replays the windows of the stimulus file on both detector lines,
// decodes the UART frames on tx and checks every count in them.
// ---------------------------------------------------------------------

module xc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          clk_period_ns = 20;
    localparam int          margin_cycles = 64;                 // slack on top of the window budget.
    localparam logic [31:0] seed          = 32'haa1da519;
    localparam              stim_file     = "dv/xc_stimulus.txt";
    localparam int          win           = xc_pkg::window_cycles;

    typedef logic [win-1:0] train_t;                            // one window of line samples.
    typedef struct packed {
        int                p0;                                  // line 0 pulse period.
        int                p1;                                  // line 1 pulse period.
        int                off;                                 // line 1 shift in cycles.
        int                jit;                                 // adds random pulses when set.
        xc_pkg::xc_frame_t counts;                              // counts before any jitter.
    } row_t;

    logic              clki;
    logic              reset;
    logic              enable;
    logic [1:0]        line_in;
    logic              tx;
    logic              overflow;
    row_t              rows[$];
    xc_pkg::xc_frame_t expect_q[$];                             // frames the DUT still owes.
    int                n_windows;
    int                frames_seen;
    realtime           drop_time;

    clock_gen #(.period_ns(clk_period_ns), .reset_cycles(8)) clock_gen_i (
        .clki  (clki),
        .reset (reset)
    );

    xc_core dut_i (
        .clki     (clki),
        .reset    (reset),
        .enable   (enable),
        .line_in  (line_in),
        .tx       (tx),
        .overflow (overflow)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, want));
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
        if (got !== want) abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, want));
    endtask

    task automatic check_frame(input string name, input xc_pkg::xc_frame_t got,
                               input xc_pkg::xc_frame_t want);
        if (got !== want) abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, want));
    endtask

    // One pulse every period cycles, starting offset cycles into the window.
    function automatic train_t pulse_train(input int period, input int offset);
        train_t t;
        t = '0;
        if (period != 0) begin
            for (int i = 0; i < win; i++) t[i] = ((i % period) == (offset % period));
        end
        return t;
    endfunction

    // Edges are high samples after low ones. Lag 1 pairs never reach back past sample 0.
    function automatic xc_pkg::xc_frame_t count_window(input train_t l0, input train_t l1,
                                                       input logic prev0, input logic prev1);
        xc_pkg::xc_frame_t c;
        train_t            e0;
        train_t            e1;
        e0 = l0 & ~{l0[win-2:0], prev0};
        e1 = l1 & ~{l1[win-2:0], prev1};
        c.count0     = 16'($countones(e0));
        c.count1     = 16'($countones(e1));
        c.coinc_lag0 = 16'($countones(e0 & e1));
        c.coinc_lag1 = 16'($countones({e0[win-2:0], 1'b0} & e1));
        return c;
    endfunction

    // Waits for a start bit and samples each bit near its middle.
    task automatic receive_byte(output logic [7:0] b);
        do @(negedge clki); while (tx !== 1'b0);
        repeat (xc_pkg::clks_per_bit / 2 - 1) @(negedge clki);
        check_bit("tx start bit", tx, 1'b0);
        for (int k = 0; k < 8; k++) begin
            repeat (xc_pkg::clks_per_bit) @(negedge clki);
            b[k] = tx;                                          // lsb arrives first.
        end
        repeat (xc_pkg::clks_per_bit) @(negedge clki);
        check_bit("tx stop bit", tx, 1'b1);
    endtask

    // ---------------------------------------------------------------------
    // stimulus
    // ---------------------------------------------------------------------
    initial begin
        int                fd;
        string             line;
        int                v[8];
        row_t              r;
        train_t            l0;
        train_t            l1;
        logic              prev0;
        logic              prev1;
        xc_pkg::xc_frame_t base;
        xc_pkg::xc_frame_t fin;
        xc_pkg::xc_frame_t want;
        int                pos;
        void'($urandom(seed));
        enable      = 1'b0;
        line_in     = '0;
        frames_seen = 0;
        prev0       = 1'b0;                                     // lines sit low through reset.
        prev1       = 1'b0;
        fd = $fopen(stim_file, "r");
        if (fd == 0) abort_run("could not open the stimulus file");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin         // hash lines describe the columns.
                if ($sscanf(line, "%h %h %h %h %h %h %h %h",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]) != 8)
                    abort_run("malformed line in the stimulus file");
                r.p0     = v[0];
                r.p1     = v[1];
                r.off    = v[2];
                r.jit    = v[3];
                r.counts = {16'(v[4]), 16'(v[5]), 16'(v[6]), 16'(v[7])};
                rows.push_back(r);
            end
        end
        $fclose(fd);
        n_windows = rows.size();
        if (n_windows == 0) abort_run("the stimulus file holds no windows");
        do @(posedge clki); while (reset !== 1'b0);
        for (int wi = 0; wi < n_windows; wi++) begin
            l0   = pulse_train(rows[wi].p0, 0);
            l1   = pulse_train(rows[wi].p1, rows[wi].off);
            base = count_window(l0, l1, prev0, prev1);
            check_frame($sformatf("stimulus row %0d counts", wi), rows[wi].counts, base);
            if (rows[wi].jit != 0) begin
                repeat ($urandom_range(8, 1)) begin
                    pos = $urandom_range(win - 2, 1);           // first and last samples stay put.
                    if ($urandom_range(1, 0) == 0) l0[pos] = 1'b1;
                    else l1[pos] = 1'b1;
                end
            end
            fin             = count_window(l0, l1, prev0, prev1);
            want.count0     = rows[wi].counts.count0 + fin.count0 - base.count0;
            want.count1     = rows[wi].counts.count1 + fin.count1 - base.count1;
            want.coinc_lag0 = rows[wi].counts.coinc_lag0 + fin.coinc_lag0 - base.coinc_lag0;
            want.coinc_lag1 = rows[wi].counts.coinc_lag1 + fin.coinc_lag1 - base.coinc_lag1;
            expect_q.push_back(want);
            for (int i = 0; i < win; i++) begin
                if (wi == 0 && i == 0) enable <= 1'b1;          // the first window opens here.
                if (wi == n_windows - 1 && i == win / 2) begin
                    enable    <= 1'b0;                          // the running window still closes.
                    drop_time = $realtime;
                end
                line_in <= {l1[i], l0[i]};
                @(posedge clki);
            end
            prev0 = l0[win-1];
            prev1 = l1[win-1];
        end
        line_in <= '0;
        while ($realtime < drop_time + 2.0 * win * clk_period_ns) @(posedge clki);
        @(negedge clki);
        check_bit("overflow", overflow, 1'b0);
        if (frames_seen != n_windows) begin
            abort_run($sformatf("only %0d of %0d frames arrived", frames_seen, n_windows));
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

    // ---------------------------------------------------------------------
    // UART receiver, watchdog and assertion monitor
    // ---------------------------------------------------------------------
    initial begin
        logic [7:0]        b [9];
        xc_pkg::xc_frame_t got;
        forever begin
            receive_byte(b[0]);
            if (expect_q.size() == 0) abort_run("a start bit appeared on tx with no frame due");
            check_byte("sync byte", b[0], xc_pkg::sync_byte);
            for (int k = 1; k < 9; k++) receive_byte(b[k]);
            got = {b[2], b[1], b[4], b[3], b[6], b[5], b[8], b[7]};  // fields go low byte first.
            check_frame($sformatf("frame %0d", frames_seen), got, expect_q.pop_front());
            frames_seen++;
        end
    end

    initial begin
        wait (n_windows != 0);
        #((n_windows + 2) * win * clk_period_ns + margin_cycles * clk_period_ns);
        abort_run($sformatf("timeout: frames did not arrive in time, %0d of %0d received",
                            frames_seen, n_windows));
    end

    initial begin
        wait (dut_i.core_checks_i.errors != 0);
        abort_run("an assertion on the buffer or the UART line failed");
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the correlator testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module xc_tb -f sim.f -o xc_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/xc_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1

// File: sim.f
design/xc_pkg.sv
design/pulse_correlator.sv
design/frame_fifo.sv
design/uart_framer.sv
design/xc_core.sv
dv/clock_gen.sv
dv/xc_properties.sv
dv/xc_tb.sv
